/* flist.f */
hw/pipe_pkg.sv
hw/pipe_ctrl.sv
hw/pipe_e1_stage.sv
hw/pipe_e2_stage.sv
hw/pipe_wb_stage.sv
hw/pipe_top.sv
bench/pipe_tb.sv

/* Bender.yml */
package:
  name: pipe_exec

sources:
  - hw/pipe_pkg.sv
  - hw/pipe_ctrl.sv
  - hw/pipe_e1_stage.sv
  - hw/pipe_e2_stage.sv
  - hw/pipe_wb_stage.sv
  - hw/pipe_top.sv
  - target: simulation
    files:
      - bench/pipe_tb.sv

/* bench/pipe_tb.sv */
//--------------------------------------
// Execute pipeline testbench
// Program builder, issuer and unit
// models, reference commit model and
// the per cycle commit checker
//--------------------------------------
`timescale 1ns/1ps

module pipe_tb;

    import pipe_pkg::*;

    localparam int              NUM_INSTR  = 48;
    localparam int              MAX_CYCLES = 3000;
    localparam logic [XLEN-1:0] PC_BASE    = 32'h0000_1000;
    localparam logic [XLEN-1:0] MEM_KEY    = 32'h5a5a_0f0f;  // Load data is address xor key
    localparam logic [2:0]      K_ALU      = 3'd0;
    localparam logic [2:0]      K_LOAD     = 3'd1;
    localparam logic [2:0]      K_STORE    = 3'd2;
    localparam logic [2:0]      K_MUL      = 3'd3;
    localparam logic [2:0]      K_BRANCH   = 3'd4;

    typedef struct packed {
        logic [2:0]       kind;
        logic             intr;
        logic             taken;
        logic [EXC_W-1:0] fault;    // Injected memory fault
        logic [XLEN-1:0]  target;
        logic [XLEN-1:0]  ra;
        logic [XLEN-1:0]  rb;
        logic [XLEN-1:0]  opcode;
    } instr_s;

    logic                 clk_i;
    logic                 rst_i;
    issue_s               issue_i;
    logic                 take_interrupt_i;
    logic                 stall_i;
    exu_s                 exu_i;
    stage_s               e1_o;
    logic [REG_IDX_W-1:0] rd_e2_o;
    logic [XLEN-1:0]      result_e2_o;
    commit_s              commit_o;
    logic                 stall_o;
    logic                 squash_o;

    instr_s          prog [NUM_INSTR];
    int              exp_q [$];         // Taken, not yet committed
    int              next_idx;
    int              error_count;
    int              commit_count;
    int              drop_count;
    int              cycles;
    int              seed_dummy;
    logic            running;
    logic            timed_out;

    // Shadows of E1 and E2 for the squash, memory and multiply models
    logic            e1s_valid;
    int              e1s_id;
    logic            sq_hold;
    logic            sh_valid;
    int              sh_id;
    logic            mem_op;
    int              mem_wait;
    logic [XLEN-1:0] mem_addr;
    logic [XLEN-1:0] mul_q;

    pipe_top DUT (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .issue_i          (issue_i),
        .take_interrupt_i (take_interrupt_i),
        .stall_i          (stall_i),
        .exu_i            (exu_i),
        .e1_o             (e1_o),
        .rd_e2_o          (rd_e2_o),
        .result_e2_o      (result_e2_o),
        .commit_o         (commit_o),
        .stall_o          (stall_o),
        .squash_o         (squash_o)
    );

    initial clk_i = 1'b0;
    always #5 clk_i = ~clk_i;

    function automatic logic [XLEN-1:0] pc_of(input int id);
        return PC_BASE + XLEN'(id * 4);
    endfunction

    function automatic instr_s make_instr(input logic [2:0] kind, input logic intr,
                                          input logic [EXC_W-1:0] fault, input logic taken,
                                          input logic [XLEN-1:0] offset, input int id);
        instr_s ins;
        ins.kind   = kind;
        ins.intr   = intr;
        ins.taken  = taken;
        ins.fault  = fault;
        ins.target = pc_of(id) + offset;
        ins.ra     = $urandom;
        ins.rb     = $urandom;
        ins.opcode = $urandom;
        return ins;
    endfunction

    //--------------------------------------
    // Reference commit model
    //--------------------------------------
    function automatic commit_s ref_commit(input instr_s ins, input int id);
        commit_s c;
        logic    lsu;
        logic    rd_valid;
        lsu      = (ins.kind == K_LOAD || ins.kind == K_STORE) && !ins.intr;
        rd_valid = (ins.kind == K_ALU || ins.kind == K_LOAD || ins.kind == K_MUL);
        c.pc     = pc_of(id);
        c.npc    = ins.taken ? ins.target : c.pc + XLEN'(PC_STEP);
        c.opcode = ins.opcode;
        if (ins.intr)
            c.exception = EXC_INTERRUPT;            // Interrupt outranks everything
        else if (ins.taken && ins.target[1:0] != 2'b00)
            c.exception = EXC_MISALIGNED_FETCH;
        else if (lsu)
            c.exception = ins.fault;
        else
            c.exception = EXC_NONE;
        c.valid = (c.exception == EXC_NONE) || (c.exception == EXC_INTERRUPT);
        c.rd    = (c.valid && rd_valid && c.exception == EXC_NONE) ?
                  ins.opcode[RD_LSB +: REG_IDX_W] : '0;
        if (lsu)
            c.result = (ins.ra + ins.rb) ^ MEM_KEY;
        else if (ins.kind == K_MUL && !ins.intr)
            c.result = ins.ra * ins.rb;
        else
            c.result = ins.ra + ins.rb;
        return c;
    endfunction

    //--------------------------------------
    // Issuer and execution unit models
    //--------------------------------------
    task automatic drive_inputs();
        instr_s ins;
        issue_i          = '0;
        take_interrupt_i = 1'b0;
        if (next_idx < NUM_INSTR)
        begin
            ins                   = prog[next_idx];   // Held until taken
            issue_i.valid         = 1'b1;
            issue_i.lsu           = (ins.kind == K_LOAD || ins.kind == K_STORE);
            issue_i.mul           = (ins.kind == K_MUL);
            issue_i.branch        = (ins.kind == K_BRANCH);
            issue_i.rd_valid      = (ins.kind == K_ALU || ins.kind == K_LOAD ||
                                     ins.kind == K_MUL);
            issue_i.branch_taken  = ins.taken;
            issue_i.branch_target = ins.target;
            issue_i.pc            = pc_of(next_idx);
            issue_i.opcode        = ins.opcode;
            issue_i.operand_ra    = ins.ra;
            issue_i.operand_rb    = ins.rb;
            take_interrupt_i      = ins.intr;
        end
        exu_i.alu_result    = e1_o.operand_ra + e1_o.operand_rb;
        exu_i.mul_result    = mul_q;
        exu_i.mem_complete  = mem_op && (mem_wait == 0);
        exu_i.mem_result    = mem_addr ^ MEM_KEY;
        exu_i.mem_exception = exu_i.mem_complete ? prog[sh_id].fault : EXC_NONE;
        stall_i             = (mem_op && mem_wait != 0) || ($urandom % 5 == 0);
    endtask

    task automatic check_commit();
        commit_s exp;
        int      id;
        assert (exp_q.size() != 0)
        else
        begin
            error_count++;
            $display("Commit at %0t arrived with no instruction outstanding", $time);
        end
        if (exp_q.size() != 0)
        begin
            id  = exp_q.pop_front();
            exp = ref_commit(prog[id], id);
            commit_count++;
            assert (commit_o.valid == exp.valid && commit_o.rd == exp.rd &&
                    commit_o.exception == exp.exception)
            else
            begin
                error_count++;
                $display("[FAIL] %0t: instr %0d valid %b rd %0d exc %h, expected %b %0d %h",
                         $time, id, commit_o.valid, commit_o.rd, commit_o.exception,
                         exp.valid, exp.rd, exp.exception);
            end
            assert (commit_o.pc == exp.pc && commit_o.npc == exp.npc &&
                    commit_o.opcode == exp.opcode)
            else
            begin
                error_count++;
                $display("[FAIL] %0t: instr %0d pc %h npc %h, expected %h %h",
                         $time, id, commit_o.pc, commit_o.npc, exp.pc, exp.npc);
            end
            if (exp.exception == EXC_NONE)
                assert (commit_o.result == exp.result)
                else
                begin
                    error_count++;
                    $display("[FAIL] %0t: instr %0d result %h, expected %h",
                             $time, id, commit_o.result, exp.result);
                end
        end
    endtask

    // Checks on stable outputs, then the bookkeeping for the next edge
    always @(negedge clk_i)
    begin
        logic [REG_IDX_W-1:0] exp_rd;
        commit_s              e2_exp;
        logic                 e2_exc;
        logic                 exp_squash;
        logic                 take_now;
        int                   idx;
        if (running)
        begin
            e2_exp     = ref_commit(prog[sh_id], sh_id);
            e2_exc     = sh_valid && e2_exp.exception != EXC_NONE &&
                         !(mem_op && mem_wait != 0);
            exp_squash = e2_exc || sq_hold;
            assert (squash_o == exp_squash)
            else
            begin
                error_count++;
                $display("[FAIL] %0t: squash_o %b, expected %b", $time, squash_o, exp_squash);
            end
            assert (e1_o.valid == e1s_valid && (!e1s_valid || e1_o.pc == pc_of(e1s_id)))
            else
            begin
                error_count++;
                $display("[FAIL] %0t: e1 valid %b pc %h, expected %b %h",
                         $time, e1_o.valid, e1_o.pc, e1s_valid, pc_of(e1s_id));
            end
            assert (stall_o == (mem_op && mem_wait != 0))
            else
            begin
                error_count++;
                $display("[FAIL] %0t: stall_o %b, expected %b", $time, stall_o,
                         (mem_op && mem_wait != 0));
            end
            exp_rd = '0;
            if (sh_valid && !stall_i && !(mem_op && mem_wait != 0) && !prog[sh_id].intr &&
                (prog[sh_id].kind == K_ALU || prog[sh_id].kind == K_LOAD ||
                 prog[sh_id].kind == K_MUL))
                exp_rd = prog[sh_id].opcode[RD_LSB +: REG_IDX_W];
            assert (rd_e2_o == exp_rd)
            else
            begin
                error_count++;
                $display("[FAIL] %0t: rd_e2_o %0d, expected %0d", $time, rd_e2_o, exp_rd);
            end
            if (sh_valid && !stall_i)
                assert (result_e2_o == e2_exp.result)
                else
                begin
                    error_count++;
                    $display("[FAIL] %0t: result_e2_o %h, expected %h",
                             $time, result_e2_o, e2_exp.result);
                end
            if (!stall_i && (commit_o.valid || commit_o.exception != EXC_NONE))
                check_commit();
            if (!stall_i)
            begin
                if (exp_squash && e1s_valid)
                begin
                    idx = -1;
                    foreach (exp_q[k])
                        if (exp_q[k] == e1s_id)
                            idx = k;
                    if (idx >= 0)
                    begin
                        exp_q.delete(idx);      // Younger op lost to the squash
                        drop_count++;
                    end
                end
                take_now = issue_i.valid && !exp_squash;
                sq_hold  = e2_exc;
                sh_valid = e1s_valid && !exp_squash;
                sh_id    = e1s_id;
                mem_op   = sh_valid && !prog[e1s_id].intr &&
                           (prog[e1s_id].kind == K_LOAD || prog[e1s_id].kind == K_STORE);
                mem_wait = $urandom % 4;
                mem_addr = prog[e1s_id].ra + prog[e1s_id].rb;
                mul_q    = e1_o.operand_ra * e1_o.operand_rb;
                e1s_valid = take_now;
                e1s_id    = take_now ? next_idx : 0;
                if (take_now)
                begin
                    exp_q.push_back(next_idx);
                    next_idx++;
                end
            end
            else if (mem_op && mem_wait != 0)
                mem_wait--;
        end
    end

    initial
    begin
        logic [2:0] kind;
        seed_dummy       = $urandom(31);
        rst_i            = 1'b1;
        issue_i          = '0;
        take_interrupt_i = 1'b0;
        stall_i          = 1'b0;
        exu_i            = '0;
        running          = 1'b0;
        timed_out        = 1'b0;
        next_idx         = 0;
        error_count      = 0;
        commit_count     = 0;
        drop_count       = 0;
        e1s_valid        = 1'b0;
        e1s_id           = 0;
        sq_hold          = 1'b0;
        sh_valid         = 1'b0;
        sh_id            = 0;
        mem_op           = 1'b0;
        mem_wait         = 0;
        mem_addr         = '0;
        mul_q            = '0;

        for (int i = 0; i < NUM_INSTR; i++)
        begin
            kind    = (i < 4) ? K_ALU : 3'($urandom % 4);
            prog[i] = make_instr(kind, 1'b0, EXC_NONE, 1'b0, '0, i);
        end
        prog[12] = make_instr(K_BRANCH, 1'b0, EXC_NONE, 1'b1, 32'h42, 12);  // Bad target
        prog[20] = make_instr(K_ALU, 1'b1, EXC_NONE, 1'b0, '0, 20);
        prog[28] = make_instr(K_LOAD, 1'b0, EXC_FAULT_LOAD, 1'b0, '0, 28);
        prog[34] = make_instr(K_BRANCH, 1'b0, EXC_NONE, 1'b1, 32'h100, 34);
        prog[40] = make_instr(K_STORE, 1'b0, EXC_PAGE_FAULT_STORE, 1'b0, '0, 40);
        prog[44] = make_instr(K_BRANCH, 1'b0, EXC_NONE, 1'b0, '0, 44);

        repeat (4) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        assert (!e1_o.valid && !commit_o.valid && commit_o.rd == '0 && !stall_o && !squash_o)
        else
        begin
            error_count++;
            $display("Pipeline outputs were not cleared by reset");
        end
        running = 1'b1;
        drive_inputs();

        cycles = 0;
        while ((next_idx < NUM_INSTR || exp_q.size() != 0) && cycles < MAX_CYCLES)
        begin
            @(posedge clk_i);
            #1;
            drive_inputs();
            cycles++;
        end
        timed_out = (cycles >= MAX_CYCLES);
        repeat (8)                              // Idle tail catches stray commits
        begin
            @(posedge clk_i);
            #1;
            drive_inputs();
        end

        if (timed_out)
            $display("Timeout with %0d instructions issued and %0d not committed",
                     next_idx, exp_q.size());
        $display("Errors %0d, commits checked %0d, squashed %0d",
                 error_count, commit_count, drop_count);
        if (error_count == 0 && !timed_out)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* hw/pipe_top.sv */
//--------------------------------------
// Execute pipeline top
// Control block plus E1, E2, WB stages
//--------------------------------------
`timescale 1ns/1ps

module pipe_top (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  pipe_pkg::issue_s                issue_i,
    input  logic                            take_interrupt_i,
    input  logic                            stall_i,
    input  pipe_pkg::exu_s                  exu_i,
    output pipe_pkg::stage_s                e1_o,
    output logic [pipe_pkg::REG_IDX_W-1:0]  rd_e2_o,
    output logic [pipe_pkg::XLEN-1:0]       result_e2_o,
    output pipe_pkg::commit_s               commit_o,
    output logic                            stall_o,
    output logic                            squash_o
);

    import pipe_pkg::*;

    stage_s           e2_w;
    logic [EXC_W-1:0] exc_e2_w;

    pipe_ctrl u_ctrl (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .stall_i  (stall_i),
        .e1_i     (e1_o),
        .e2_i     (e2_w),
        .exu_i    (exu_i),
        .stall_o  (stall_o),
        .squash_o (squash_o),
        .exc_e2_o (exc_e2_w)
    );

    pipe_e1_stage u_e1 (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .issue_i          (issue_i),
        .take_interrupt_i (take_interrupt_i),
        .stall_i          (stall_i),
        .squash_i         (squash_o),
        .e1_o             (e1_o)
    );

    pipe_e2_stage u_e2 (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .stall_i  (stall_i),
        .squash_i (squash_o),
        .e1_i     (e1_o),
        .exu_i    (exu_i),
        .e2_o     (e2_w),
        .result_o (result_e2_o),
        .rd_o     (rd_e2_o)
    );

    // Commit takes the bypassed E2 result
    pipe_wb_stage u_wb (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .stall_i  (stall_i),
        .e2_i     (e2_w),
        .result_i (result_e2_o),
        .exc_e2_i (exc_e2_w),
        .commit_o (commit_o)
    );

endmodule

/* hw/pipe_wb_stage.sv */
//--------------------------------------
// Writeback commit register
// Fault handling and rd suppression
//--------------------------------------
`timescale 1ns/1ps

module pipe_wb_stage (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        stall_i,
    input  pipe_pkg::stage_s            e2_i,
    input  logic [pipe_pkg::XLEN-1:0]   result_i,
    input  logic [pipe_pkg::EXC_W-1:0]  exc_e2_i,
    output pipe_pkg::commit_s           commit_o
);

    import pipe_pkg::*;

    logic             valid_q;
    logic             rd_valid_q;
    logic [EXC_W-1:0] exc_q;
    logic [XLEN-1:0]  result_q;
    logic [XLEN-1:0]  pc_q;
    logic [XLEN-1:0]  npc_q;
    logic [XLEN-1:0]  opcode_q;
    logic             valid_w;

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            valid_q    <= 1'b0;
            rd_valid_q <= 1'b0;
            exc_q      <= EXC_NONE;
        end
        else if (!stall_i)
        begin
            // Memory faults never retire
            valid_q    <= e2_i.valid & ~is_mem_fault(exc_e2_i);
            rd_valid_q <= e2_i.ctrl.rd_valid & ~(|exc_e2_i);
            exc_q      <= exc_e2_i;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (!stall_i)
        begin
            result_q <= result_i;       // Bypassed E2 value
            pc_q     <= e2_i.pc;
            npc_q    <= e2_i.npc;
            opcode_q <= e2_i.opcode;
        end
    end

    //--------------------------------------
    // Commit bundle
    //--------------------------------------
    assign valid_w = valid_q & ~stall_i;

    always_comb
    begin
        commit_o.valid     = valid_w;
        commit_o.rd        = (valid_w && rd_valid_q) ? opcode_q[RD_LSB +: REG_IDX_W] : '0;
        commit_o.result    = result_q;
        commit_o.pc        = pc_q;
        commit_o.npc       = npc_q;
        commit_o.opcode    = opcode_q;
        commit_o.exception = exc_q;
    end

endmodule

/* hw/pipe_e2_stage.sv */
//--------------------------------------
// E2 result stage
// ALU capture, memory and multiply
// bypass, destination forward
//--------------------------------------
`timescale 1ns/1ps

module pipe_e2_stage (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            stall_i,
    input  logic                            squash_i,
    input  pipe_pkg::stage_s                e1_i,
    input  pipe_pkg::exu_s                  exu_i,
    output pipe_pkg::stage_s                e2_o,
    output logic [pipe_pkg::XLEN-1:0]       result_o,
    output logic [pipe_pkg::REG_IDX_W-1:0]  rd_o
);

    import pipe_pkg::*;

    logic             valid_q;
    ctrl_s            ctrl_q;
    logic [EXC_W-1:0] exc_q;
    logic [XLEN-1:0]  pc_q;
    logic [XLEN-1:0]  npc_q;
    logic [XLEN-1:0]  opcode_q;
    logic [XLEN-1:0]  ra_q;
    logic [XLEN-1:0]  rb_q;
    logic [XLEN-1:0]  result_q;

    logic             active_w;
    logic             mem_op_w;
    logic             mem_wait_w;

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            valid_q <= 1'b0;
            ctrl_q  <= '0;
            exc_q   <= EXC_NONE;
        end
        else if (!stall_i)
        begin
            if (squash_i)
            begin
                valid_q <= 1'b0;
                ctrl_q  <= '0;
                exc_q   <= EXC_NONE;
            end
            else
            begin
                valid_q <= e1_i.valid;
                ctrl_q  <= e1_i.ctrl;
                if (e1_i.ctrl.intr)
                    exc_q <= EXC_INTERRUPT;
                else if (|e1_i.exception)
                begin
                    // Faulting op continues only to report its cause
                    valid_q <= 1'b0;
                    exc_q   <= e1_i.exception;
                end
                else
                    exc_q <= EXC_NONE;
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (!stall_i)
        begin
            pc_q     <= e1_i.pc;
            npc_q    <= e1_i.npc;
            opcode_q <= e1_i.opcode;
            ra_q     <= e1_i.operand_ra;
            rb_q     <= e1_i.operand_rb;
            result_q <= exu_i.alu_result;   // Sampled while op sits in E1
        end
    end

    //--------------------------------------
    // Bypass and destination
    //--------------------------------------
    assign active_w   = valid_q & ~stall_i;
    assign mem_op_w   = ctrl_q.load | ctrl_q.store;
    assign mem_wait_w = mem_op_w & ~exu_i.mem_complete;

    always_comb
    begin
        result_o = result_q;
        if (active_w && mem_op_w)
            result_o = exu_i.mem_result;
        else if (active_w && ctrl_q.mul)
            result_o = exu_i.mul_result;
    end

    assign rd_o = (active_w && ctrl_q.rd_valid && !mem_wait_w) ?
                  opcode_q[RD_LSB +: REG_IDX_W] : '0;

    always_comb
    begin
        e2_o.valid      = valid_q;
        e2_o.ctrl       = ctrl_q;
        e2_o.pc         = pc_q;
        e2_o.npc        = npc_q;
        e2_o.opcode     = opcode_q;
        e2_o.operand_ra = ra_q;
        e2_o.operand_rb = rb_q;
        e2_o.exception  = exc_q;
        e2_o.result     = result_q;
    end

endmodule

/* hw/pipe_e1_stage.sv */
//--------------------------------------
// E1 issue capture
// Unit decode, next PC and the
// misaligned branch target check
//--------------------------------------
`timescale 1ns/1ps

module pipe_e1_stage (
    input  logic              clk_i,
    input  logic              rst_i,
    input  pipe_pkg::issue_s  issue_i,
    input  logic              take_interrupt_i,
    input  logic              stall_i,
    input  logic              squash_i,
    output pipe_pkg::stage_s  e1_o
);

    import pipe_pkg::*;

    logic             take_w;
    logic             br_misaligned_w;
    ctrl_s            ctrl_w;
    logic [EXC_W-1:0] exc_w;

    logic             valid_q;
    ctrl_s            ctrl_q;
    logic [EXC_W-1:0] exc_q;
    logic [XLEN-1:0]  pc_q;
    logic [XLEN-1:0]  npc_q;
    logic [XLEN-1:0]  opcode_q;
    logic [XLEN-1:0]  ra_q;
    logic [XLEN-1:0]  rb_q;

    assign take_w = issue_i.valid & ~stall_i & ~squash_i;

    assign br_misaligned_w = issue_i.branch_taken & (|issue_i.branch_target[1:0]);

    //--------------------------------------
    // Decode
    //--------------------------------------
    always_comb
    begin
        ctrl_w.alu      = ~(issue_i.lsu | issue_i.mul);
        ctrl_w.load     = issue_i.lsu &  issue_i.rd_valid & ~take_interrupt_i;
        ctrl_w.store    = issue_i.lsu & ~issue_i.rd_valid & ~take_interrupt_i;
        ctrl_w.mul      = issue_i.mul & ~take_interrupt_i;
        ctrl_w.branch   = issue_i.branch & ~take_interrupt_i;
        ctrl_w.rd_valid = issue_i.rd_valid & ~take_interrupt_i;
        ctrl_w.intr     = take_interrupt_i;
    end

    // Issue side fault first, then bad branch target
    assign exc_w = (|issue_i.exception) ? issue_i.exception :
                   br_misaligned_w      ? EXC_MISALIGNED_FETCH : EXC_NONE;

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            valid_q <= 1'b0;
            ctrl_q  <= '0;
            exc_q   <= EXC_NONE;
        end
        else if (!stall_i)
        begin
            valid_q <= take_w;          // Empty slot when nothing taken
            ctrl_q  <= take_w ? ctrl_w : '0;
            exc_q   <= take_w ? exc_w : EXC_NONE;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (take_w)
        begin
            pc_q     <= issue_i.pc;
            npc_q    <= issue_i.branch_taken ? issue_i.branch_target
                                             : issue_i.pc + XLEN'(PC_STEP);
            opcode_q <= issue_i.opcode;
            ra_q     <= issue_i.operand_ra;
            rb_q     <= issue_i.operand_rb;
        end
    end

    always_comb
    begin
        e1_o.valid      = valid_q;
        e1_o.ctrl       = ctrl_q;
        e1_o.pc         = pc_q;
        e1_o.npc        = npc_q;
        e1_o.opcode     = opcode_q;
        e1_o.operand_ra = ra_q;
        e1_o.operand_rb = rb_q;
        e1_o.exception  = exc_q;
        e1_o.result     = '0;   // ALU answers during E1
    end

endmodule

/* hw/pipe_ctrl.sv */
//--------------------------------------
// Pipeline control
// Memory stall, E2 exception merge and
// the two cycle E1/E2 squash
//--------------------------------------
`timescale 1ns/1ps

module pipe_ctrl (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        stall_i,
    input  pipe_pkg::stage_s            e1_i,
    input  pipe_pkg::stage_s            e2_i,
    input  pipe_pkg::exu_s              exu_i,
    output logic                        stall_o,
    output logic                        squash_o,
    output logic [pipe_pkg::EXC_W-1:0]  exc_e2_o
);

    import pipe_pkg::*;

    logic mem_op_e2_w;
    logic squash_w;
    logic squash_q;

    assign mem_op_e2_w = e2_i.ctrl.load | e2_i.ctrl.store;

    // Memory access in E2 waits for the LSU
    assign stall_o = mem_op_e2_w & ~exu_i.mem_complete;

    //--------------------------------------
    // Exception merge
    //--------------------------------------
    always_comb
    begin
        if (e2_i.valid && mem_op_e2_w && exu_i.mem_complete)
            exc_e2_o = exu_i.mem_exception;     // LSU fault wins over nothing
        else
            exc_e2_o = e2_i.exception;
    end

    assign squash_w = |exc_e2_o;

    // Second squash cycle
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            squash_q <= 1'b0;
        else if (!stall_i)
            squash_q <= squash_w;
    end

    assign squash_o = squash_w | squash_q;

endmodule

/* hw/pipe_pkg.sv */
//--------------------------------------
// Execute pipeline package
// Widths, field positions, exception
// codes, fault classifier and the
// issue, stage, commit and unit structs
//--------------------------------------
package pipe_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int EXC_W     = 6;
    localparam int RD_LSB    = 7;   // rd field in opcode
    localparam int PC_STEP   = 4;

    //--------------------------------------
    // Exception codes
    //--------------------------------------
    localparam logic [EXC_W-1:0] EXC_NONE             = 6'h00;
    localparam logic [EXC_W-1:0] EXC_MISALIGNED_FETCH = 6'h10;
    localparam logic [EXC_W-1:0] EXC_MISALIGNED_LOAD  = 6'h14;
    localparam logic [EXC_W-1:0] EXC_FAULT_LOAD       = 6'h15;
    localparam logic [EXC_W-1:0] EXC_MISALIGNED_STORE = 6'h16;
    localparam logic [EXC_W-1:0] EXC_FAULT_STORE      = 6'h17;
    localparam logic [EXC_W-1:0] EXC_PAGE_FAULT_LOAD  = 6'h1d;
    localparam logic [EXC_W-1:0] EXC_PAGE_FAULT_STORE = 6'h1f;
    localparam logic [EXC_W-1:0] EXC_INTERRUPT        = 6'h20;  // Top bit marks interrupt

    // Faults raised by the memory unit
    function automatic logic is_mem_fault(input logic [EXC_W-1:0] code);
        logic hit;
        case (code)
            EXC_MISALIGNED_LOAD,
            EXC_FAULT_LOAD,
            EXC_MISALIGNED_STORE,
            EXC_FAULT_STORE,
            EXC_PAGE_FAULT_LOAD,
            EXC_PAGE_FAULT_STORE: hit = 1'b1;
            default:              hit = 1'b0;
        endcase
        return hit;
    endfunction

    //--------------------------------------
    // Structs
    //--------------------------------------
    typedef struct packed {
        logic             valid;
        logic             lsu;
        logic             mul;
        logic             branch;
        logic             rd_valid;
        logic             branch_taken;
        logic [XLEN-1:0]  branch_target;
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  opcode;
        logic [XLEN-1:0]  operand_ra;
        logic [XLEN-1:0]  operand_rb;
        logic [EXC_W-1:0] exception;
    } issue_s;

    typedef struct packed {
        logic alu;
        logic load;
        logic store;
        logic mul;
        logic branch;
        logic rd_valid;
        logic intr;
    } ctrl_s;

    typedef struct packed {
        logic             valid;
        ctrl_s            ctrl;
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  npc;
        logic [XLEN-1:0]  opcode;
        logic [XLEN-1:0]  operand_ra;
        logic [XLEN-1:0]  operand_rb;
        logic [EXC_W-1:0] exception;
        logic [XLEN-1:0]  result;
    } stage_s;

    typedef struct packed {
        logic                 valid;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      result;
        logic [XLEN-1:0]      pc;
        logic [XLEN-1:0]      npc;
        logic [XLEN-1:0]      opcode;
        logic [EXC_W-1:0]     exception;
    } commit_s;

    typedef struct packed {
        logic [XLEN-1:0]  alu_result;
        logic             mem_complete;
        logic [XLEN-1:0]  mem_result;
        logic [EXC_W-1:0] mem_exception;
        logic [XLEN-1:0]  mul_result;
    } exu_s;

endpackage
